// File: Makefile
# Verilator flow for the data memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_dmem_subsys
RTL_TOP   ?= dmem_subsys
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
RTL_FILES ?= verilog/dmem_pkg.sv verilog/pma_pkg.sv verilog/dmem_pma.sv \
             verilog/dmem_write_buffer.sv verilog/dmem_obi_limiter.sv verilog/dmem_subsys.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/dmem_subsys_assertions.sv
// Limiter bus protocol checks
module dmem_subsys_assertions (
  input logic                               clk,
  input logic                               rst_n,
  input logic [dmem_pkg::OUTSTANDING_W-1:0] count,
  input logic                               obi_req_o,
  input logic [31:0]                        obi_addr_o,
  input logic                               obi_we_o,
  input logic [3:0]                         obi_be_o,
  input logic [31:0]                        obi_wdata_o,
  input logic [1:0]                         obi_memtype_o,
  input logic                               obi_gnt_i,
  input logic                               obi_rvalid_i
);

  //////////////////////////////
  // Outstanding count
  //////////////////////////////

  // Counter stays within the configured limit
  count_within_limit: assert property (@(posedge clk) disable iff (!rst_n)
    count <= dmem_pkg::OUTSTANDING_W'(dmem_pkg::MAX_OUTSTANDING))
    else $error("outstanding count above limit");

  // A response needs a granted transaction to answer
  rvalid_needs_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    obi_rvalid_i |-> (count != '0))
    else $error("rvalid with no outstanding transaction");

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // Pending request holds its address phase until granted
  addr_phase_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_req_o && !obi_gnt_i) |=> (obi_req_o && $stable(obi_addr_o) && $stable(obi_we_o)
      && $stable(obi_be_o) && $stable(obi_wdata_o) && $stable(obi_memtype_o)))
    else $error("address phase changed while waiting for grant");

endmodule

bind dmem_obi_limiter dmem_subsys_assertions limiter_assertions_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .count         (count),
  .obi_req_o     (obi_req_o),
  .obi_addr_o    (obi_addr_o),
  .obi_we_o      (obi_we_o),
  .obi_be_o      (obi_be_o),
  .obi_wdata_o   (obi_wdata_o),
  .obi_memtype_o (obi_memtype_o),
  .obi_gnt_i     (obi_gnt_i),
  .obi_rvalid_i  (obi_rvalid_i)
);

// File: sim/tb_dmem_subsys.sv
// Data memory subsystem testbench
module tb_dmem_subsys;

  localparam int          CLK_PERIOD     = 100;
  localparam int          DRIVE_DELAY    = 10;
  localparam int          RST_CYCLES     = 5;
  localparam int          NUM_DIRECTED   = 5;
  localparam int          NUM_RANDOM     = 40;
  localparam int          NUM_REQS       = NUM_DIRECTED + NUM_RANDOM;
  localparam int unsigned TIMEOUT_CYCLES = 4 * NUM_REQS * 8;
  localparam logic [31:0] ERR_ADDR       = 32'h2000_0010;

  logic        clk;
  logic        rst_n;
  logic        core_req_i;
  logic [31:0] core_addr_i;
  logic        core_we_i;
  logic [3:0]  core_be_i;
  logic [31:0] core_wdata_i;
  logic        core_gnt_o;
  logic        core_rvalid_o;
  logic [31:0] core_rdata_o;
  logic        core_err_o;
  logic        obi_req_o;
  logic [31:0] obi_addr_o;
  logic        obi_we_o;
  logic [3:0]  obi_be_o;
  logic [31:0] obi_wdata_o;
  logic [1:0]  obi_memtype_o;
  logic        obi_gnt_i;
  logic        obi_rvalid_i;
  logic [31:0] obi_rdata_i;
  logic        obi_err_i;

  // Memory model grant mode is 0 random, 1 held low or 2 held high
  logic [1:0]  gnt_mode;
  int unsigned cyc;
  int          outstanding;

  // Memory model state
  logic [31:0] model_mem [logic [31:0]];
  logic [31:0] pend_rdata [$];
  logic        pend_err [$];
  int unsigned pend_due [$];

  // Expected traffic in core grant order
  logic [31:0]             shadow_mem [logic [31:0]];
  dmem_pkg::obi_data_req_t exp_bus [$];
  logic [31:0]             exp_rdata [$];
  logic                    exp_err [$];
  logic                    exp_is_read [$];

  dmem_subsys dmem_subsys_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_req_i    (core_req_i),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i),
    .core_gnt_o    (core_gnt_o),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .core_err_o    (core_err_o),
    .obi_req_o     (obi_req_o),
    .obi_addr_o    (obi_addr_o),
    .obi_we_o      (obi_we_o),
    .obi_be_o      (obi_be_o),
    .obi_wdata_o   (obi_wdata_o),
    .obi_memtype_o (obi_memtype_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i),
    .obi_err_i     (obi_err_i)
  );

  //////////////////////////////
  // Clock and cycle limit
  //////////////////////////////

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Counted on the falling edge so sampling at the rising edge sees a stable value
  always @(negedge clk) begin
    cyc++;
    if (cyc >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  // Expected memory type scans the last region first so the lowest match wins
  function automatic logic [1:0] expected_memtype(input logic [31:0] addr);
    logic [1:0] mt;
    mt = pma_pkg::PMA_DEFAULT_MEMTYPE;
    for (int i = pma_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((addr & pma_pkg::PMA_REGIONS[i].mask) == pma_pkg::PMA_REGIONS[i].base) begin
        mt = pma_pkg::PMA_REGIONS[i].memtype;
      end
    end
    return mt;
  endfunction

  // Word content before any write depends on the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ addr ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] key);
    return model_mem.exists(key) ? model_mem[key] : fill_word(key);
  endfunction

  function automatic logic [31:0] shadow_read(input logic [31:0] key);
    return shadow_mem.exists(key) ? shadow_mem[key] : fill_word(key);
  endfunction

  task automatic compare_trans(input dmem_pkg::obi_data_req_t act,
                               input dmem_pkg::obi_data_req_t exp);
    if (act.addr !== exp.addr) begin
      stop_with_error($sformatf("error: obi_addr_o act=%h exp=%h", act.addr, exp.addr));
    end
    if (act.we !== exp.we) begin
      stop_with_error($sformatf("error: obi_we_o act=%h exp=%h", act.we, exp.we));
    end
    if (act.be !== exp.be) begin
      stop_with_error($sformatf("error: obi_be_o act=%h exp=%h", act.be, exp.be));
    end
    if (act.wdata !== exp.wdata) begin
      stop_with_error($sformatf("error: obi_wdata_o act=%h exp=%h", act.wdata, exp.wdata));
    end
    if (act.memtype !== exp.memtype) begin
      stop_with_error($sformatf("error: obi_memtype_o act=%h exp=%h",
                                act.memtype, exp.memtype));
    end
  endtask

  task automatic compare_rsp(input logic [31:0] act_data, input logic act_err,
                             input logic [31:0] exp_data, input logic exp_e,
                             input logic check_data);
    if (act_err !== exp_e) begin
      stop_with_error($sformatf("error: core_err_o act=%h exp=%h", act_err, exp_e));
    end
    if (check_data && (act_data !== exp_data)) begin
      stop_with_error($sformatf("error: core_rdata_o act=%h exp=%h", act_data, exp_data));
    end
  endtask

  //////////////////////////////
  // Bus memory model
  //////////////////////////////

  always @(posedge clk) begin : memory_model
    logic [31:0] key;
    logic [1:0]  mode;
    int unsigned roll;
    mode = gnt_mode;
    if (rst_n && obi_req_o && obi_gnt_i) begin
      key = {obi_addr_o[31:2], 2'b00};
      pend_rdata.push_back(obi_we_o ? 32'h0 : model_read(key));
      pend_err.push_back(obi_addr_o == ERR_ADDR);
      // Response seen one to three cycles after the grant
      pend_due.push_back(cyc + $urandom_range(0, 2));
      if (obi_we_o) begin
        model_mem[key] = merge_bytes(model_read(key), obi_wdata_o, obi_be_o);
      end
    end
    #(DRIVE_DELAY);
    if (!rst_n) begin
      obi_gnt_i    = 1'b0;
      obi_rvalid_i = 1'b0;
      obi_rdata_i  = 32'h0;
      obi_err_i    = 1'b0;
    end else begin
      roll = $urandom_range(0, 99);
      case (mode)
        2'd1:    obi_gnt_i = 1'b0;
        2'd2:    obi_gnt_i = 1'b1;
        default: obi_gnt_i = (roll < 65);
      endcase
      if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
        obi_rvalid_i = 1'b1;
        obi_rdata_i  = pend_rdata.pop_front();
        obi_err_i    = pend_err.pop_front();
        void'(pend_due.pop_front());
      end else begin
        obi_rvalid_i = 1'b0;
        obi_rdata_i  = 32'h0;
        obi_err_i    = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(posedge clk) begin : compare_proc
    dmem_pkg::obi_data_req_t t;
    dmem_pkg::obi_data_req_t act;
    logic [31:0]             key;
    // Reset and the first cycles after it stay quiet
    if (!rst_n || cyc <= RST_CYCLES + 2) begin
      if (obi_req_o !== 1'b0) begin
        stop_with_error("obi_req_o was high during or right after reset");
      end
      if (core_rvalid_o !== 1'b0) begin
        stop_with_error("core_rvalid_o was high during or right after reset");
      end
    end
    if (rst_n) begin
      if (obi_req_o && outstanding >= dmem_pkg::MAX_OUTSTANDING) begin
        stop_with_error("obi_req_o was high with the outstanding limit reached");
      end
      if (core_req_i && core_gnt_o) begin
        t.addr    = core_addr_i;
        t.we      = core_we_i;
        t.be      = core_be_i;
        t.wdata   = core_wdata_i;
        t.memtype = expected_memtype(core_addr_i);
        exp_bus.push_back(t);
        key = {core_addr_i[31:2], 2'b00};
        exp_err.push_back(core_addr_i == ERR_ADDR);
        exp_is_read.push_back(!core_we_i);
        exp_rdata.push_back(core_we_i ? 32'h0 : shadow_read(key));
        if (core_we_i) begin
          shadow_mem[key] = merge_bytes(shadow_read(key), core_wdata_i, core_be_i);
        end
      end
      if (obi_req_o && obi_gnt_i) begin
        if (exp_bus.size() == 0) begin
          stop_with_error("Bus transaction granted without a matching core request");
        end
        act.addr    = obi_addr_o;
        act.we      = obi_we_o;
        act.be      = obi_be_o;
        act.wdata   = obi_wdata_o;
        act.memtype = obi_memtype_o;
        compare_trans(act, exp_bus.pop_front());
      end
      if (core_rvalid_o) begin
        if (exp_rdata.size() == 0) begin
          stop_with_error("Response returned to the core with none expected");
        end
        compare_rsp(core_rdata_o, core_err_o, exp_rdata.pop_front(), exp_err.pop_front(),
                    exp_is_read.pop_front());
      end
      outstanding = outstanding + int'(obi_req_o && obi_gnt_i) - int'(obi_rvalid_i);
    end
  end

  //////////////////////////////
  // Core driver
  //////////////////////////////

  // All driver tasks start and end a drive delay after a rising edge
  task automatic drive_req(input logic [31:0] addr, input logic we, input logic [3:0] be,
                           input logic [31:0] wdata);
    core_req_i   = 1'b1;
    core_addr_i  = addr;
    core_we_i    = we;
    core_be_i    = be;
    core_wdata_i = wdata;
  endtask

  task automatic drive_idle();
    core_req_i   = 1'b0;
    core_addr_i  = 32'h0;
    core_we_i    = 1'b0;
    core_be_i    = 4'h0;
    core_wdata_i = 32'h0;
  endtask

  task automatic wait_grant();
    forever begin
      @(posedge clk);
      if (core_gnt_o) begin
        break;
      end
    end
    #(DRIVE_DELAY);
    drive_idle();
  endtask

  task automatic expect_blocked(input int n, input string what);
    repeat (n) begin
      @(posedge clk);
      if (core_gnt_o) begin
        stop_with_error({what, " was granted while it should wait"});
      end
    end
    #(DRIVE_DELAY);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
    end
    #(DRIVE_DELAY);
  endtask

  // Grant everything until all expected traffic has completed
  task automatic drain_all();
    gnt_mode = 2'd2;
    forever begin
      @(negedge clk);
      if (exp_bus.size() == 0 && exp_rdata.size() == 0) begin
        break;
      end
    end
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  initial begin : stimulus
    logic [31:0] addr;
    logic        we;
    void'($urandom(32'h82d1));
    cyc         = 0;
    outstanding = 0;
    gnt_mode    = 2'd0;
    rst_n       = 1'b0;
    drive_idle();
    obi_gnt_i    = 1'b0;
    obi_rvalid_i = 1'b0;
    obi_rdata_i  = 32'h0;
    obi_err_i    = 1'b0;
    repeat (RST_CYCLES) begin
      @(posedge clk);
    end
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    idle_cycles(3);

    // Non-bufferable requests wait for the bus grant
    // The memory model takes a new grant mode at the next rising edge
    drain_all();
    gnt_mode = 2'd1;
    idle_cycles(1);
    drive_req(32'h2000_0004, 1'b0, 4'hF, 32'h0);
    expect_blocked(4, "I/O read with obi_gnt_i low");
    gnt_mode = 2'd2;
    wait_grant();
    drain_all();
    gnt_mode = 2'd1;
    idle_cycles(1);
    drive_req(32'h0000_0008, 1'b1, 4'hF, 32'hC0DE_0008);
    expect_blocked(4, "Code write with obi_gnt_i low");
    gnt_mode = 2'd2;
    wait_grant();

    // Posted RAM write is taken at once and later ones wait on the held entry
    drain_all();
    gnt_mode = 2'd1;
    idle_cycles(1);
    drive_req(32'h1000_0000, 1'b1, 4'hF, 32'h1111_2222);
    @(posedge clk);
    if (!core_gnt_o) begin
      stop_with_error("RAM write was not granted in the cycle it was issued");
    end
    #(DRIVE_DELAY);
    drive_req(32'h1000_0000, 1'b1, 4'h3, 32'h3333_4444);
    expect_blocked(4, "Second RAM write with a buffered write waiting");
    gnt_mode = 2'd2;
    wait_grant();
    // Grant stays high one more cycle and drains the held write while the read waits
    gnt_mode = 2'd1;
    drive_req(32'h1000_0000, 1'b0, 4'hF, 32'h0);
    expect_blocked(4, "Read with the write buffer full");
    gnt_mode = 2'd2;
    wait_grant();
    drain_all();

    // Random mix over all regions and an unmapped one
    gnt_mode = 2'd0;
    repeat (NUM_RANDOM) begin
      case ($urandom_range(0, 3))
        0:       addr = 32'h0000_0000;
        1:       addr = 32'h1000_0000;
        2:       addr = 32'h2000_0000;
        default: addr = 32'h3000_0000;
      endcase
      addr = addr | (32'($urandom_range(0, 15)) << 2);
      we   = 1'($urandom_range(0, 1));
      if (we) begin
        drive_req(addr, 1'b1, 4'($urandom_range(1, 15)), $urandom());
      end else begin
        drive_req(addr, 1'b0, 4'hF, 32'h0);
      end
      wait_grant();
      idle_cycles($urandom_range(0, 3));
    end
    drain_all();
    idle_cycles(2);

    if (exp_bus.size() == 0 && exp_rdata.size() == 0 && pend_due.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_with_error("Transactions were left without completion at the end of the run");
    end
  end

endmodule

// File: tb.f
verilog/dmem_pkg.sv
verilog/pma_pkg.sv
verilog/dmem_pma.sv
verilog/dmem_write_buffer.sv
verilog/dmem_obi_limiter.sv
verilog/dmem_subsys.sv
sim/dmem_subsys_assertions.sv
sim/tb_dmem_subsys.sv

// File: verilog/dmem_obi_limiter.sv
// Outstanding transaction limiter
module dmem_obi_limiter (
  input  logic                   clk,
  input  logic                   rst_n,

  // Upstream, from the write buffer
  input  logic                   valid_i,
  input  dmem_pkg::obi_data_req_t trans_i,
  output logic                   ready_o,

  // OBI address phase
  output logic                   obi_req_o,
  output logic [31:0]            obi_addr_o,
  output logic                   obi_we_o,
  output logic [3:0]             obi_be_o,
  output logic [31:0]            obi_wdata_o,
  output logic [1:0]             obi_memtype_o,
  input  logic                   obi_gnt_i,

  // OBI response phase, only counted here
  input  logic                   obi_rvalid_i
);

  logic [dmem_pkg::OUTSTANDING_W-1:0] count;
  logic                               below_limit;
  logic                               issue;

  //////////////////////////////
  // Outstanding count
  //////////////////////////////

  assign below_limit = count < dmem_pkg::OUTSTANDING_W'(dmem_pkg::MAX_OUTSTANDING);

  // Address phase completes on req and gnt together
  assign issue = obi_req_o && obi_gnt_i;

  // Grant and response in the same cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (issue && !obi_rvalid_i) begin
      count <= count + 1'b1;
    end else if (!issue && obi_rvalid_i) begin
      count <= count - 1'b1;
    end
  end

  //////////////////////////////
  // Bus outputs
  //////////////////////////////

  // At the limit the request is hidden from the bus
  assign obi_req_o = valid_i && below_limit;
  assign ready_o   = obi_gnt_i && below_limit;

  assign obi_addr_o    = trans_i.addr;
  assign obi_we_o      = trans_i.we;
  assign obi_be_o      = trans_i.be;
  assign obi_wdata_o   = trans_i.wdata;
  assign obi_memtype_o = trans_i.memtype;

endmodule

// File: verilog/dmem_pkg.sv
// Data memory bus definitions
package dmem_pkg;

  //////////////////////////////
  // Request payload
  //////////////////////////////

  // One load/store request as it travels from the core to the bus
  // Memory type bit 0 marks bufferable, bit 1 marks cacheable
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [1:0]  memtype;
  } obi_data_req_t;

  //////////////////////////////
  // Write buffer FSM
  //////////////////////////////

  // Empty passes requests through, full holds one posted write
  typedef enum logic {
    WBUF_EMPTY,
    WBUF_FULL
  } write_buffer_state_e;

  //////////////////////////////
  // Outstanding limit
  //////////////////////////////

  // Granted transactions that may wait for a response at once
  localparam int MAX_OUTSTANDING = 2;

  // Width of the outstanding counter
  // Must hold the value MAX_OUTSTANDING
  localparam int OUTSTANDING_W = 2;

endpackage

// File: verilog/dmem_pma.sv
// Memory attribute lookup
module dmem_pma (
  // Core request port
  input  logic                   core_req_i,
  input  logic [31:0]            core_addr_i,
  input  logic                   core_we_i,
  input  logic [3:0]             core_be_i,
  input  logic [31:0]            core_wdata_i,
  output logic                   core_gnt_o,

  // Tagged request towards the write buffer
  output logic                   valid_o,
  output dmem_pkg::obi_data_req_t trans_o,
  input  logic                   ready_i
);

  logic [1:0] memtype;
  logic       hit;

  //////////////////////////////
  // Region lookup
  //////////////////////////////

  // First matching region supplies the memory type
  always_comb begin
    memtype = pma_pkg::PMA_DEFAULT_MEMTYPE;
    hit     = 1'b0;
    for (int i = 0; i < pma_pkg::PMA_NUM_REGIONS; i++) begin
      if (!hit && ((core_addr_i & pma_pkg::PMA_REGIONS[i].mask) ==
                   pma_pkg::PMA_REGIONS[i].base)) begin
        memtype = pma_pkg::PMA_REGIONS[i].memtype;
        hit     = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Pack the core fields together with the looked-up type
  always_comb begin
    trans_o.addr    = core_addr_i;
    trans_o.we      = core_we_i;
    trans_o.be      = core_be_i;
    trans_o.wdata   = core_wdata_i;
    trans_o.memtype = memtype;
  end

  // Handshake is untouched by the lookup
  assign valid_o    = core_req_i;
  assign core_gnt_o = ready_i;

endmodule

// File: verilog/dmem_subsys.sv
// Data memory subsystem top
module dmem_subsys (
  input  logic        clk,
  input  logic        rst_n,

  // Core side
  input  logic        core_req_i,
  input  logic [31:0] core_addr_i,
  input  logic        core_we_i,
  input  logic [3:0]  core_be_i,
  input  logic [31:0] core_wdata_i,
  output logic        core_gnt_o,
  output logic        core_rvalid_o,
  output logic [31:0] core_rdata_o,
  output logic        core_err_o,

  // Bus side
  output logic        obi_req_o,
  output logic [31:0] obi_addr_o,
  output logic        obi_we_o,
  output logic [3:0]  obi_be_o,
  output logic [31:0] obi_wdata_o,
  output logic [1:0]  obi_memtype_o,
  input  logic        obi_gnt_i,
  input  logic        obi_rvalid_i,
  input  logic [31:0] obi_rdata_i,
  input  logic        obi_err_i
);

  // Lookup to buffer
  logic                    pma_valid;
  dmem_pkg::obi_data_req_t pma_trans;
  logic                    pma_ready;

  // Buffer to limiter
  logic                    wbuf_valid;
  dmem_pkg::obi_data_req_t wbuf_trans;
  logic                    wbuf_ready;

  //////////////////////////////
  // Request path
  //////////////////////////////

  dmem_pma pma_i (
    .core_req_i   (core_req_i),
    .core_addr_i  (core_addr_i),
    .core_we_i    (core_we_i),
    .core_be_i    (core_be_i),
    .core_wdata_i (core_wdata_i),
    .core_gnt_o   (core_gnt_o),
    .valid_o      (pma_valid),
    .trans_o      (pma_trans),
    .ready_i      (pma_ready)
  );

  dmem_write_buffer write_buffer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (pma_valid),
    .trans_i (pma_trans),
    .ready_o (pma_ready),
    .valid_o (wbuf_valid),
    .trans_o (wbuf_trans),
    .ready_i (wbuf_ready)
  );

  dmem_obi_limiter limiter_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (wbuf_valid),
    .trans_i       (wbuf_trans),
    .ready_o       (wbuf_ready),
    .obi_req_o     (obi_req_o),
    .obi_addr_o    (obi_addr_o),
    .obi_we_o      (obi_we_o),
    .obi_be_o      (obi_be_o),
    .obi_wdata_o   (obi_wdata_o),
    .obi_memtype_o (obi_memtype_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_rvalid_i  (obi_rvalid_i)
  );

  //////////////////////////////
  // Response path
  //////////////////////////////

  // Responses return in order, nothing to reorder or hold
  assign core_rvalid_o = obi_rvalid_i;
  assign core_rdata_o  = obi_rdata_i;
  assign core_err_o    = obi_err_i;

endmodule

// File: verilog/dmem_write_buffer.sv
// Single-entry write buffer
module dmem_write_buffer (
  input  logic                   clk,
  input  logic                   rst_n,

  // Upstream, from the attribute lookup
  input  logic                   valid_i,
  input  dmem_pkg::obi_data_req_t trans_i,
  output logic                   ready_o,

  // Downstream, towards the outstanding limiter
  output logic                   valid_o,
  output dmem_pkg::obi_data_req_t trans_o,
  input  logic                   ready_i
);

  dmem_pkg::write_buffer_state_e state;
  dmem_pkg::write_buffer_state_e next_state;
  dmem_pkg::obi_data_req_t       trans_q;
  logic                          push;
  logic                          bufferable;

  // Only writes to bufferable memory may be posted
  // Reads always wait for the bus so ordering stays simple
  assign bufferable = trans_i.memtype[0] && trans_i.we;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dmem_pkg::WBUF_EMPTY;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    push       = 1'b0;
    case (state)
      dmem_pkg::WBUF_EMPTY: begin
        // Bus refuses a posted write, so keep it here
        if (valid_i && bufferable && !ready_i) begin
          next_state = dmem_pkg::WBUF_FULL;
          push       = 1'b1;
        end
      end
      dmem_pkg::WBUF_FULL: begin
        // Held entry leaves on a downstream ready
        if (ready_i) begin
          if (valid_i && bufferable) begin
            // Next posted write takes the freed slot
            push = 1'b1;
          end else begin
            next_state = dmem_pkg::WBUF_EMPTY;
          end
        end
      end
      default: begin
        next_state = dmem_pkg::WBUF_EMPTY;
      end
    endcase
  end

  //////////////////////////////
  // Entry storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      trans_q <= trans_i;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Full: a posted write is taken only when the held one drains
  // Empty: posted writes always taken, others need the bus
  assign ready_o = (state == dmem_pkg::WBUF_FULL) ? (bufferable && ready_i)
                                                  : (bufferable || ready_i);

  // Held entry has priority on the bus
  assign valid_o = (state == dmem_pkg::WBUF_FULL) || valid_i;
  assign trans_o = (state == dmem_pkg::WBUF_FULL) ? trans_q : trans_i;

endmodule

// File: verilog/pma_pkg.sv
// Physical memory attribute table
package pma_pkg;

  //////////////////////////////
  // Region description
  //////////////////////////////

  // An address hits a region when (addr & mask) == base
  typedef struct packed {
    logic [31:0] base;
    logic [31:0] mask;
    logic [1:0]  memtype;
  } pma_region_t;

  localparam int PMA_NUM_REGIONS = 3;

  //////////////////////////////
  // Region table
  //////////////////////////////

  // Lower index wins when regions overlap
  // Code: cacheable only
  // RAM: bufferable and cacheable
  // I/O: neither
  localparam pma_region_t PMA_REGIONS [0:PMA_NUM_REGIONS-1] = '{
    '{base: 32'h0000_0000, mask: 32'hFFFF_0000, memtype: 2'b10},
    '{base: 32'h1000_0000, mask: 32'hFFFF_0000, memtype: 2'b11},
    '{base: 32'h2000_0000, mask: 32'hFFFF_0000, memtype: 2'b00}
  };

  // Unmapped addresses are neither bufferable nor cacheable
  localparam logic [1:0] PMA_DEFAULT_MEMTYPE = 2'b00;

endpackage
